/* files.f */
rtl/field_timing_pkg.sv
rtl/bubble_geom_pkg.sv
rtl/bmc_ctrl_if.sv
rtl/bmc_sync.sv
rtl/access_fsm.sv
rtl/field_rotation.sv
rtl/bout_cycle_counter.sv
rtl/bubble_timing_top.sv
verif/bubble_timing_assert.sv
verif/tb_bubble_timing.sv

/* run.sh */
#!/bin/sh
# build and run the bubble timing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_bubble_timing \
    -f files.f \
    -o sim_bubble_timing > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/sim_bubble_timing > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench passed" sim.log; then
    exit 0
fi
exit 1

/* verif/bubble_timing_testdata.txt */
# nen bss bsen repen booten swapen cycles acc abspage cyclenum
# inputs are pin levels, expected values checked at the end of the step, -1 skips a check
0 1 1 1 0 1 24 0 1951 8191
0 0 1 1 0 1 24 1 1951 8191
0 1 0 1 0 1 48340 6 2051 2051
0 1 1 1 0 1 600 0 2052 8191
0 1 1 1 1 1 24 0 2052 8191
0 0 1 1 1 1 24 1 2052 8191
0 1 0 1 1 1 1000 4 0 8191
0 1 0 0 1 1 24 7 0 8191
0 1 0 1 1 1 335800 7 700 583
0 1 1 1 1 1 1000 0 701 8191
0 0 1 1 1 1 24 1 701 8191
0 1 0 1 1 1 1000 4 702 8191
0 1 0 1 1 0 24 5 702 8191
0 1 0 1 1 1 2000 5 707 8191
0 1 1 1 1 1 1000 0 707 8191
1 0 0 0 0 0 200 0 707 8191
1 1 0 1 0 1 200 0 707 8191
0 1 1 1 0 1 50 0 707 8191

/* verif/tb_bubble_timing.sv */
`timescale 1ns/1ps

module tb_bubble_timing;

    localparam int INIT_ABS     = 1951;
    localparam int NONE         = 8191;
    localparam int ACC_RST      = 0;
    localparam int ACC_BOOT     = 6;
    localparam int ACC_USER     = 7;
    localparam int LAUNCH_GAP   = 480;  // one rotation after the first
    localparam int PY_TO_LAUNCH = 238;  // 568 -> 89 -> 326

    logic        MCLK = 1'b0;
    logic        rst_n, nEN, nBSS, nBSEN, nREPEN, nBOOTEN, nSWAPEN;
    logic        CLKOUT, nBINCLKEN, nBOUTCLKEN;
    logic [2:0]  ACCTYPE;
    logic [12:0] BOUTCYCLENUM;
    logic [11:0] ABSPAGE;

    int steps[$];  // 10 columns per step
    int limit = 0, cyc = 0, errors = 0, events = 0;
    int mon_cyc = 0, clk_len = 0, clk_edges = 0, bout_low = 0;
    int last_bout = -1, last_py = -1, n_py = 0, run_ticks = 0, acc_d = 0;
    logic clk_prev = 1'b1, first_pending = 1'b1;

    bubble_timing_top #(.INIT_ABS_PAGE(12'd1951), .SYNC_STAGES(3)) u_dut (
        .MCLK, .rst_n, .nEN, .nBSS, .nBSEN, .nREPEN, .nBOOTEN, .nSWAPEN,
        .CLKOUT, .ACCTYPE, .BOUTCYCLENUM, .nBINCLKEN, .nBOUTCLKEN, .ABSPAGE
    );

    always #4 MCLK = ~MCLK;  // 8 ns

    task automatic check_equal(input string what, input int got, input int exp);
        if (exp >= 0)
        begin
            assert (got == exp)
            else
            begin
                errors++;
                $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
            end
        end
    endtask

    // bit cycle number after k data ticks, n ticks in total
    function automatic int expected_cycle(input int acc, input int k, input int n);
        if (acc != ACC_BOOT && acc != ACC_USER)
            return NONE;
        if (k <= 98)
            return NONE;  // propagation delay
        if (acc == ACC_BOOT)
            return (INIT_ABS + n) % 4106;
        return (k - 99 < 583) ? k - 99 : 583;
    endfunction

    task automatic read_steps();
        int    fd, n;
        int    v[10];
        string line;
        fd = $fopen("verif/bubble_timing_testdata.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("could not open the test data file");
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
                if (n == 10)  // comment and blank lines drop out here
                begin
                    foreach (v[j])
                        steps.push_back(v[j]);
                    limit += v[6];
                end
            end
            $fclose(fd);
            limit += 2000;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus, one data file step at a time
    initial
    begin
        int b;
        {nEN, nBSS, nBSEN, nREPEN, nBOOTEN, nSWAPEN} = 6'b011101;  // boot rest
        rst_n = 1'b0;
        read_steps();
        repeat (4) @(negedge MCLK);
        rst_n = 1'b1;
        @(negedge MCLK);
        check_equal("nBINCLKEN after reset", int'(nBINCLKEN), 1);
        check_equal("nBOUTCLKEN after reset", int'(nBOUTCLKEN), 0);
        for (int s = 0; s < steps.size() / 10; s++)
        begin
            b       = s * 10;
            nEN     = (steps[b] != 0);
            nBSS    = (steps[b+1] != 0);
            nBSEN   = (steps[b+2] != 0);
            nREPEN  = (steps[b+3] != 0);
            nBOOTEN = (steps[b+4] != 0);
            nSWAPEN = (steps[b+5] != 0);
            repeat (steps[b+6]) @(negedge MCLK);
            check_equal($sformatf("step %0d ACCTYPE", s), int'(ACCTYPE), steps[b+7]);
            check_equal($sformatf("step %0d ABSPAGE", s), int'(ABSPAGE), steps[b+8]);
            check_equal($sformatf("step %0d BOUTCYCLENUM", s), int'(BOUTCYCLENUM), steps[b+9]);
        end
        $display("%0d steps, %0d strobe events, %0d errors", steps.size() / 10, events, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // strobe and clock monitor, sampled mid cycle
    always @(negedge MCLK)
    begin
        if (rst_n)
        begin
            mon_cyc++;
            if (CLKOUT != clk_prev)
            begin
                if (clk_edges > 0)  // first high phase stretched by reset
                    check_equal("CLKOUT level length", clk_len, 6);
                clk_edges++;
                clk_len = 1;
            end
            else
                clk_len++;
            clk_prev = CLKOUT;

            if (!nBOUTCLKEN)
                bout_low++;
            else
            begin
                if (bout_low == 1)  // launch pulse just ended
                begin
                    if (last_py >= 0)
                        check_equal("+Y to launch", mon_cyc - 1 - last_py, PY_TO_LAUNCH);
                    if (last_bout >= 0)
                        check_equal("launch spacing", mon_cyc - 1 - last_bout, LAUNCH_GAP);
                    last_bout = mon_cyc - 1;
                    events++;
                end
                else if (bout_low > 1)
                begin
                    first_pending = 1'b1;  // field left rest
                    last_bout     = -1;
                    last_py       = -1;
                end
                bout_low = 0;
            end
            if (bout_low > 1 && int'(ACCTYPE) == ACC_RST)
                run_ticks = 0;

            if (!nBINCLKEN)
            begin
                assert (bout_low < 2)
                else
                begin
                    errors++;
                    $display("sample strobe pulsed while the field was stopped, at %0t", $time);
                end
                if (first_pending)
                    first_pending = 1'b0;  // the 88 sample, not a +Y
                else
                begin
                    last_py = mon_cyc;
                    n_py++;
                    if (acc_d == ACC_BOOT || acc_d == ACC_USER)
                        run_ticks++;
                    else
                        run_ticks = 0;
                    check_equal("ABSPAGE at +Y", int'(ABSPAGE), (INIT_ABS + n_py) % 2053);
                    check_equal("BOUTCYCLENUM at +Y", int'(BOUTCYCLENUM),
                                expected_cycle(acc_d, run_ticks, n_py));
                    events++;
                end
            end
            acc_d = int'(ACCTYPE);  // state seen by the next tick
        end
    end

    // run limit
    always @(posedge MCLK)
    begin
        cyc++;
        if (limit > 0 && cyc > limit)
        begin
            $display("timeout, run went past %0d cycles", limit);
            $display("Testbench failed");
            $finish;
        end
    end

endmodule

/* verif/bubble_timing_assert.sv */
`timescale 1ns/1ps

module bubble_timing_assert import bubble_geom_pkg::*; (
    input logic      MCLK,
    input logic      rst_n,
    input logic      field_running,
    input logic      nBOUTCLKEN,
    input logic      nBINCLKEN,
    input abs_page_t ABSPAGE
);

    ////////////////////////////////////////////////////////////
    // launch strobe is a single MCLK pulse per rotation
    launch_single: assert property (@(posedge MCLK) disable iff (!rst_n)
        (field_running && !nBOUTCLKEN) |=> nBOUTCLKEN)
        else $error("launch strobe low for two cycles while the field runs");

    sample_single: assert property (@(posedge MCLK) disable iff (!rst_n)
        !nBINCLKEN |=> nBINCLKEN)  // 88 and 568 never adjacent
        else $error("sample strobe low for two cycles");

    page_range: assert property (@(posedge MCLK) disable iff (!rst_n)
        ABSPAGE < LOOP_LEN)
        else $error("absolute page out of loop range");

endmodule

bind bubble_timing_top bubble_timing_assert u_assert (
    .MCLK(MCLK), .rst_n(rst_n), .field_running(field_running),
    .nBOUTCLKEN(nBOUTCLKEN), .nBINCLKEN(nBINCLKEN), .ABSPAGE(ABSPAGE)
);

/* rtl/bubble_timing_top.sv */
`timescale 1ns/1ps

module bubble_timing_top import field_timing_pkg::*, bubble_geom_pkg::*; #(
    parameter abs_page_t INIT_ABS_PAGE = 12'd1951,
    parameter int        SYNC_STAGES   = 3
) (
    input  logic       MCLK,          // 48 MHz
    input  logic       rst_n,
    input  logic       nEN,
    input  logic       nBSS,
    input  logic       nBSEN,
    input  logic       nREPEN,
    input  logic       nBOOTEN,
    input  logic       nSWAPEN,
    output logic       CLKOUT,        // 4 MHz to the controller
    output access_t    ACCTYPE,
    output cycle_num_t BOUTCYCLENUM,
    output logic       nBINCLKEN,
    output logic       nBOUTCLKEN,
    output abs_page_t  ABSPAGE
);

    logic field_running;
    logic plus_y_tick;

    bmc_ctrl_if u_bus ();

    ////////////////////////////////////////////////////////////
    bmc_sync #(.SYNC_STAGES(SYNC_STAGES)) u_sync (
        .MCLK, .rst_n, .nEN, .nBSS, .nBSEN, .nREPEN, .nBOOTEN, .nSWAPEN,
        .CLKOUT, .bus(u_bus.src)
    );

    access_fsm u_fsm (.MCLK, .rst_n, .bus(u_bus.dst), .acc(ACCTYPE));

    field_rotation #(.INIT_ABS_PAGE(INIT_ABS_PAGE)) u_field (
        .MCLK, .rst_n, .acc(ACCTYPE), .field_running, .plus_y_tick,
        .ABSPAGE, .nBOUTCLKEN, .nBINCLKEN
    );

    bout_cycle_counter #(.INIT_ABS_PAGE(INIT_ABS_PAGE)) u_cycle (
        .MCLK, .rst_n, .acc(ACCTYPE), .field_running, .plus_y_tick, .BOUTCYCLENUM
    );

endmodule

/* rtl/bout_cycle_counter.sv */
`timescale 1ns/1ps

module bout_cycle_counter import field_timing_pkg::*, bubble_geom_pkg::*; #(
    parameter abs_page_t INIT_ABS_PAGE = 12'd1951
) (
    input  logic       MCLK,
    input  logic       rst_n,
    input  access_t    acc,
    input  logic       field_running,
    input  logic       plus_y_tick,
    output cycle_num_t BOUTCYCLENUM
);

    // all ones marks a counter not in use
    localparam delay_cnt_t DLY_UNUSED  = '1;
    localparam page_cnt_t  PAGE_UNUSED = '1;

    delay_cnt_t dly;
    page_cnt_t  pcnt;
    cycle_num_t bcnt;      // bootloop position, runs regardless of access
    cycle_num_t bcnt_nxt;
    page_cnt_t  pcnt_nxt;

    assign bcnt_nxt = (bcnt == BOOT_CYCLES - cycle_num_t'(1)) ? cycle_num_t'(0)
                                                              : bcnt + cycle_num_t'(1);
    assign pcnt_nxt = (pcnt == PAGE_UNUSED) ? page_cnt_t'(0) : pcnt + page_cnt_t'(1);

    ////////////////////////////////////////////////////////////
    // bit cycle bookkeeping, once per +Y
    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            BOUTCYCLENUM <= CYCLE_NONE;
            dly          <= DLY_UNUSED;
            pcnt         <= PAGE_UNUSED;
            bcnt         <= cycle_num_t'(INIT_ABS_PAGE);
        end
        else if (!field_running)
        begin
            if (acc == RST)  // stopped and released
            begin
                BOUTCYCLENUM <= CYCLE_NONE;
                dly          <= DLY_UNUSED;
                pcnt         <= PAGE_UNUSED;
            end
        end
        else if (plus_y_tick)
        begin
            bcnt <= bcnt_nxt;
            if (!acc[1])  // IDLE or SWAP, nothing on the line
            begin
                BOUTCYCLENUM <= CYCLE_NONE;
                dly          <= DLY_UNUSED;
                pcnt         <= PAGE_UNUSED;
            end
            else if (dly == DLY_UNUSED || dly < PROP_DELAY - delay_cnt_t'(1))
            begin
                // bits still travelling to the detector
                BOUTCYCLENUM <= CYCLE_NONE;
                dly          <= (dly == DLY_UNUSED) ? delay_cnt_t'(0) : dly + delay_cnt_t'(1);
                pcnt         <= PAGE_UNUSED;
            end
            else if (!acc[0])
                BOUTCYCLENUM <= bcnt_nxt;  // bootloop read
            else if (pcnt == PAGE_UNUSED || pcnt < PAGE_BITS - page_cnt_t'(1))
            begin
                pcnt         <= pcnt_nxt;  // page read, holds at 583
                BOUTCYCLENUM <= cycle_num_t'(pcnt_nxt);
            end
        end
    end

endmodule

/* rtl/field_rotation.sv */
`timescale 1ns/1ps

module field_rotation import field_timing_pkg::*, bubble_geom_pkg::*; #(
    parameter abs_page_t INIT_ABS_PAGE = 12'd1951
) (
    input  logic      MCLK,
    input  logic      rst_n,
    input  access_t   acc,
    output logic      field_running,
    output logic      plus_y_tick,
    output abs_page_t ABSPAGE,
    output logic      nBOUTCLKEN,
    output logic      nBINCLKEN
);

    //   +Y 568 / -X 208 / -Y 328 / +X 448
    field_cnt_t fcnt;  // 0 = field at rest

    ////////////////////////////////////////////////////////////
    // field position counter
    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
            fcnt <= '0;
        else if (fcnt == '0)
        begin
            if (acc[2])
                fcnt <= FIELD_START;  // bit 2 starts the rotation
        end
        else if (fcnt == FIELD_MINUS_X && !acc[2])
            fcnt <= '0;  // stop only at -X
        else if (fcnt == FIELD_PLUS_Y)
            fcnt <= FIELD_RESTART;
        else
            fcnt <= fcnt + field_cnt_t'(1);
    end

    assign field_running = (fcnt != '0);
    assign plus_y_tick   = (fcnt == FIELD_PLUS_Y);

    // loop position under the detector, one step per +Y
    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
            ABSPAGE <= INIT_ABS_PAGE;
        else if (plus_y_tick)
            ABSPAGE <= (ABSPAGE == LOOP_LEN - abs_page_t'(1)) ? abs_page_t'(0)
                                                              : ABSPAGE + abs_page_t'(1);
    end

    ////////////////////////////////////////////////////////////
    // launch and sample strobes
    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            nBOUTCLKEN <= 1'b0;  // low at rest
            nBINCLKEN  <= 1'b1;
        end
        else
        begin
            nBOUTCLKEN <= !(fcnt == '0 || fcnt == FIELD_BOUT);
            nBINCLKEN  <= !(fcnt == FIELD_BIN_FIRST || fcnt == FIELD_PLUS_Y);
        end
    end

endmodule

/* rtl/access_fsm.sv */
`timescale 1ns/1ps

module access_fsm import field_timing_pkg::*; (
    input  logic    MCLK,
    input  logic    rst_n,
    bmc_ctrl_if.dst bus,
    output access_t acc
);

    ////////////////////////////////////////////////////////////
    // strobe patterns, {bss, booten, bsen, repen, swapen}
    localparam logic [4:0] PAT_BOOT_REST  = 5'b10111;  // idle after power up or after bootloop
    localparam logic [4:0] PAT_BOOT_START = 5'b00111;  // shift start, bootloop selected
    localparam logic [4:0] PAT_BOOT_RUN   = 5'b10011;  // bootloop shifting
    localparam logic [4:0] PAT_USER_REST  = 5'b11111;
    localparam logic [4:0] PAT_USER_START = 5'b01111;  // shift start, pages
    localparam logic [4:0] PAT_USER_RUN   = 5'b11011;  // seek or page load
    localparam logic [4:0] PAT_REPLICATE  = 5'b11001;
    localparam logic [4:0] PAT_SWAP       = 5'b11010;

    logic [4:0] pattern;
    access_t    acc_nxt;

    assign pattern = {bus.bss, bus.booten, bus.bsen, bus.repen, bus.swapen};

    always_comb
    begin
        acc_nxt = acc;  // default hold
        case (pattern)
            PAT_BOOT_REST, PAT_USER_REST:
            begin
                if (acc != STBY)
                    acc_nxt = RST;
            end
            PAT_BOOT_START, PAT_USER_START:
            begin
                if (acc == RST)
                    acc_nxt = STBY;
            end
            PAT_BOOT_RUN:
            begin
                if (acc == STBY || acc == RST)
                    acc_nxt = BOOT;
            end
            PAT_USER_RUN:
            begin
                if (acc == STBY || acc == RST)
                    acc_nxt = IDLE;  // field moves, no data yet
            end
            PAT_REPLICATE: if (acc == IDLE) acc_nxt = USER;
            PAT_SWAP:      if (acc == IDLE) acc_nxt = SWAP;
            default:       acc_nxt = acc;
        endcase
    end

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
            acc <= RST;
        else
            acc <= acc_nxt;
    end

endmodule

/* rtl/bmc_sync.sv */
`timescale 1ns/1ps

module bmc_sync import field_timing_pkg::*; #(
    parameter int SYNC_STAGES = 3
) (
    input  logic       MCLK,
    input  logic       rst_n,
    input  logic       nEN,
    input  logic       nBSS,
    input  logic       nBSEN,
    input  logic       nREPEN,
    input  logic       nBOOTEN,
    input  logic       nSWAPEN,
    output logic       CLKOUT,
    bmc_ctrl_if.src    bus
);

    // {swapen, bss, bsen, repen, booten}, idle with booten low
    localparam logic [4:0] STROBE_REST = 5'b11110;

    div_cnt_t   phase;
    logic [4:0] gated;
    logic [4:0] sync_pipe [SYNC_STAGES];

    ////////////////////////////////////////////////////////////
    // divider and 4 MHz clock
    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            phase  <= '0;
            CLKOUT <= 1'b1;  // rest level
        end
        else
        begin
            phase <= (phase == DIV_LAST) ? div_cnt_t'(0) : phase + div_cnt_t'(1);
            if (phase == CLKOUT_RISE)
                CLKOUT <= 1'b1;
            else if (phase == CLKOUT_FALL)
                CLKOUT <= 1'b0;  // controller launches on this edge
        end
    end

    // disabled: everything idle
    assign gated[4] = nEN | nSWAPEN;
    assign gated[3] = nEN | nBSS;
    assign gated[2] = nEN | nBSEN;
    assign gated[1] = nEN | nREPEN | ~nBOOTEN;  // no replicate during bootloop access
    assign gated[0] = ~nEN & nBOOTEN;

    ////////////////////////////////////////////////////////////
    // delay line, then sample on the 12 MHz phases
    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < SYNC_STAGES; i++)
                sync_pipe[i] <= STROBE_REST;
            {bus.swapen, bus.bss, bus.bsen, bus.repen, bus.booten} <= STROBE_REST;
        end
        else
        begin
            sync_pipe[0] <= gated;
            for (int i = 1; i < SYNC_STAGES; i++)
                sync_pipe[i] <= sync_pipe[i-1];
            if (SAMPLE_PHASES[phase])  // phases 3, 7, 11
                {bus.swapen, bus.bss, bus.bsen, bus.repen, bus.booten} <=
                    sync_pipe[SYNC_STAGES-1];
        end
    end

endmodule

/* rtl/bmc_ctrl_if.sv */
`timescale 1ns/1ps

// captured controller strobes, all active low, level only
interface bmc_ctrl_if;
    logic bss;     // shift start
    logic bsen;    // shift enable, field rotates
    logic repen;   // replicator
    logic booten;  // bootloop select
    logic swapen;  // swap gate

    modport src (
        output bss, bsen, repen, booten, swapen
    );

    modport dst (
        input bss, bsen, repen, booten, swapen
    );
endinterface

/* rtl/bubble_geom_pkg.sv */
package bubble_geom_pkg;

    ////////////////////////////////////////////////////////////
    // minor loop geometry
    typedef logic [11:0] abs_page_t;

    localparam abs_page_t LOOP_LEN = 12'd2053;  // positions per minor loop

    // serial bit numbering as seen by the emulator
    typedef logic [12:0] cycle_num_t;

    localparam cycle_num_t CYCLE_NONE  = 13'd8191;  // nothing valid on the line
    localparam cycle_num_t BOOT_CYCLES = 13'd4106;  // two bootloops, interleaved

    typedef logic [9:0] page_cnt_t;

    localparam page_cnt_t PAGE_BITS = 10'd584;  // 292 even + 292 odd loops

    ////////////////////////////////////////////////////////////
    // rotations from replicator to detector
    typedef logic [6:0] delay_cnt_t;

    localparam delay_cnt_t PROP_DELAY = 7'd98;

endpackage

/* rtl/field_timing_pkg.sv */
package field_timing_pkg;

    ////////////////////////////////////////////////////////////
    // rotating field position, counted in MCLK
    typedef logic [9:0] field_cnt_t;

    localparam field_cnt_t FIELD_START     = 10'd1;    // first count after leaving rest
    localparam field_cnt_t FIELD_MINUS_X   = 10'd208;  // -X, the only place the field may stop
    localparam field_cnt_t FIELD_BOUT      = 10'd326;  // data launch, just ahead of -Y at 328
    localparam field_cnt_t FIELD_PLUS_Y    = 10'd568;  // +Y, one bit cycle done
    localparam field_cnt_t FIELD_RESTART   = 10'd89;   // wrap target, 480 MCLK per rotation
    localparam field_cnt_t FIELD_BIN_FIRST = 10'd88;   // first input sample of a run

    ////////////////////////////////////////////////////////////
    // divide-by-12 for the 4 MHz controller clock
    typedef logic [3:0] div_cnt_t;

    localparam div_cnt_t DIV_LAST    = 4'd11;
    localparam div_cnt_t CLKOUT_RISE = 4'd5;
    localparam div_cnt_t CLKOUT_FALL = 4'd11;

    // one bit per phase, set on the 12 MHz sample points 3, 7, 11
    localparam logic [11:0] SAMPLE_PHASES = 12'b1000_1000_1000;

    // bit 2: field rotates, bit 1: data moves
    typedef enum logic [2:0] {
        RST  = 3'b000,
        STBY = 3'b001,
        BOOT = 3'b110,
        USER = 3'b111,
        IDLE = 3'b100,
        SWAP = 3'b101
    } access_t;

endpackage
